//--- common/sram_pkg.sv
package sram_pkg;

  // AXI4-Lite payload widths used on every port of the model
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t resp_okay   = 2'b00;
  localparam axi_resp_t resp_slverr = 2'b10;

  // state of the latency generator
  typedef logic [7:0] lfsr_t;

  // a latency of 2 is the shortest the channels can turn a transaction around,
  // so it counts as no added delay
  localparam int min_latency = 2;

endpackage

//--- sram_model/lfsr8.sv
module lfsr8 #(
  parameter sram_pkg::lfsr_t seed = 8'h95
) (
  input  logic            clk,
  input  logic            rstn,
  output sram_pkg::lfsr_t state
);
  import sram_pkg::*;

  logic feedback;

  // taps 8,6,5,4 give the full 255-state sequence
  assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= seed;
    end else begin
      state <= {state[6:0], feedback};
    end
  end

endmodule

//--- sram_model/axil_read_channel.sv
module axil_read_channel #(
  parameter int              jitter_bits = 4,
  parameter sram_pkg::lfsr_t seed        = 8'h95
) (
  input  logic                clk,
  input  logic                rstn,
  input  sram_pkg::addr_t     araddr,
  input  logic                arvalid,
  output logic                arready,
  output sram_pkg::word_t     rdata,
  output sram_pkg::axi_resp_t rresp,
  output logic                rvalid,
  input  logic                rready,
  output logic                rd_fire,
  output sram_pkg::addr_t     rd_addr,
  input  sram_pkg::word_t     rd_data,
  input  logic                rd_ok
);
  import sram_pkg::*;

  // one extra bit so that the floor on top of the jitter never wraps
  localparam int cnt_bits = jitter_bits + 1;

  lfsr_t               lfsr_state;
  logic [cnt_bits-1:0] latency;
  logic [cnt_bits-1:0] cnt;
  logic                busy;
  logic                ar_hs;

  lfsr8 #(
    .seed(seed)
  ) u_lfsr (
    .clk  (clk),
    .rstn (rstn),
    .state(lfsr_state)
  );

  // arready is low exactly while a read is waiting for its fetch
  assign busy    = ~arready;
  assign ar_hs   = arvalid & arready;
  assign latency = cnt_bits'(lfsr_state[jitter_bits-1:0]) + cnt_bits'(min_latency);

  // the fetch waits for the previous R beat to be taken
  assign rd_fire = busy & (cnt == cnt_bits'(1)) & ~rvalid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
      cnt     <= '0;
    end else begin
      if (rvalid & rready) begin
        rvalid <= 1'b0;
      end
      if (ar_hs) begin
        arready <= 1'b0;
        cnt     <= latency;
      end else if (busy && cnt > cnt_bits'(1)) begin
        cnt <= cnt - cnt_bits'(1);
      end
      if (rd_fire) begin
        rvalid  <= 1'b1;
        arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr <= araddr;
    end
    if (rd_fire) begin
      rdata <= rd_data;
      rresp <= rd_ok ? resp_okay : resp_slverr;
    end
  end

endmodule

//--- sram_model/axil_write_channel.sv
module axil_write_channel #(
  parameter int              jitter_bits = 4,
  parameter sram_pkg::lfsr_t seed        = 8'h3c
) (
  input  logic                clk,
  input  logic                rstn,
  input  sram_pkg::addr_t     awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  sram_pkg::word_t     wdata,
  input  sram_pkg::strb_t     wstrb,
  input  logic                wvalid,
  output logic                wready,
  output sram_pkg::axi_resp_t bresp,
  output logic                bvalid,
  input  logic                bready,
  output logic                wr_fire,
  output sram_pkg::addr_t     wr_addr,
  output sram_pkg::word_t     wr_data,
  output sram_pkg::strb_t     wr_strb,
  input  logic                wr_ok
);
  import sram_pkg::*;

  localparam int cnt_bits = jitter_bits + 1;

  lfsr_t               lfsr_state;
  logic [cnt_bits-1:0] latency;
  logic [cnt_bits-1:0] cnt;
  logic                aw_hs;
  logic                w_hs;
  logic                start;
  logic                busy;

  lfsr8 #(
    .seed(seed)
  ) u_lfsr (
    .clk  (clk),
    .rstn (rstn),
    .state(lfsr_state)
  );

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  // the count starts on whichever beat completes the pair,
  // or on the cycle both beats arrive together
  assign start = (aw_hs & (~wready | w_hs)) | (w_hs & (~awready | aw_hs));

  // both ready lines stay low from the second beat until the commit
  assign busy = ~awready & ~wready;

  assign latency = cnt_bits'(lfsr_state[jitter_bits-1:0]) + cnt_bits'(min_latency);

  // a held B response keeps the next commit waiting
  assign wr_fire = busy & (cnt == cnt_bits'(1)) & ~bvalid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      awready <= 1'b1;
      wready  <= 1'b1;
      bvalid  <= 1'b0;
      cnt     <= '0;
    end else begin
      if (bvalid & bready) begin
        bvalid <= 1'b0;
      end
      if (aw_hs) begin
        awready <= 1'b0;
      end
      if (w_hs) begin
        wready <= 1'b0;
      end
      if (start) begin
        cnt <= latency;
      end else if (busy && cnt > cnt_bits'(1)) begin
        cnt <= cnt - cnt_bits'(1);
      end
      if (wr_fire) begin
        bvalid  <= 1'b1;
        awready <= 1'b1;
        wready  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr <= awaddr;
    end
    if (w_hs) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
    if (wr_fire) begin
      bresp <= wr_ok ? resp_okay : resp_slverr;
    end
  end

endmodule

//--- sram_model/sram_core.sv
module sram_core #(
  parameter int word_bits = 8
) (
  input  logic            clk,
  input  logic            rd_fire,
  input  sram_pkg::addr_t rd_addr,
  output sram_pkg::word_t rd_data,
  output logic            rd_ok,
  input  logic            wr_fire,
  input  sram_pkg::addr_t wr_addr,
  input  sram_pkg::word_t wr_data,
  input  sram_pkg::strb_t wr_strb,
  output logic            wr_ok
);
  import sram_pkg::*;

  localparam int depth = 1 << word_bits;

  word_t                mem [depth] = '{default: '0};
  logic [word_bits-1:0] rd_idx;
  logic [word_bits-1:0] wr_idx;
  logic                 fwd;
  word_t                rd_word;

  // byte addresses, so the word index starts at bit 2
  assign rd_idx = rd_addr[word_bits+1:2];
  assign wr_idx = wr_addr[word_bits+1:2];

  assign rd_ok = (rd_addr >> (word_bits + 2)) == '0;
  assign wr_ok = (wr_addr >> (word_bits + 2)) == '0;

  // a fetch on the commit edge of the same word sees the new bytes
  assign fwd = rd_fire & wr_fire & wr_ok & (rd_idx == wr_idx);

  always_comb begin
    rd_word = mem[rd_idx];
    for (int b = 0; b < 4; b++) begin
      if (fwd && wr_strb[b]) begin
        rd_word[8*b +: 8] = wr_data[8*b +: 8];
      end
    end
  end

  // out-of-range reads return zero data alongside SLVERR
  assign rd_data = rd_ok ? rd_word : '0;

  always_ff @(posedge clk) begin
    if (wr_fire && wr_ok) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- rtl/axil_sram_top.sv
module axil_sram_top #(
  parameter int              word_bits   = 8,
  parameter int              jitter_bits = 4,
  parameter sram_pkg::lfsr_t seed_rd     = 8'h95,
  parameter sram_pkg::lfsr_t seed_wr     = 8'h3c
) (
  input  logic                clk,
  input  logic                rstn,

  input  sram_pkg::addr_t     araddr,
  input  logic                arvalid,
  output logic                arready,

  output sram_pkg::word_t     rdata,
  output sram_pkg::axi_resp_t rresp,
  output logic                rvalid,
  input  logic                rready,

  input  sram_pkg::addr_t     awaddr,
  input  logic                awvalid,
  output logic                awready,

  input  sram_pkg::word_t     wdata,
  input  sram_pkg::strb_t     wstrb,
  input  logic                wvalid,
  output logic                wready,

  output sram_pkg::axi_resp_t bresp,
  output logic                bvalid,
  input  logic                bready
);
  import sram_pkg::*;

  logic  rd_fire;
  addr_t rd_addr;
  word_t rd_data;
  logic  rd_ok;

  logic  wr_fire;
  addr_t wr_addr;
  word_t wr_data;
  strb_t wr_strb;
  logic  wr_ok;

  // separate seeds keep the read and write latencies uncorrelated
  axil_read_channel #(
    .jitter_bits(jitter_bits),
    .seed       (seed_rd)
  ) u_read (
    .clk    (clk),
    .rstn   (rstn),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .rd_fire(rd_fire),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .rd_ok  (rd_ok)
  );

  axil_write_channel #(
    .jitter_bits(jitter_bits),
    .seed       (seed_wr)
  ) u_write (
    .clk    (clk),
    .rstn   (rstn),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .wr_fire(wr_fire),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb),
    .wr_ok  (wr_ok)
  );

  sram_core #(
    .word_bits(word_bits)
  ) u_core (
    .clk    (clk),
    .rd_fire(rd_fire),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .rd_ok  (rd_ok),
    .wr_fire(wr_fire),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb),
    .wr_ok  (wr_ok)
  );

endmodule

//--- dv/tb_axil_sram.sv
module tb_axil_sram;
  import sram_pkg::*;

  localparam int word_bits = 8;
  localparam int idx_top   = word_bits + 2;
  localparam int n_reads   = 400;
  localparam int n_writes  = 400;
  // 800 transactions of up to 17 cycles latency and 16 cycles of slack, rounded up
  localparam int timeout_cycles = 30000;

  logic      clk;
  logic      rstn;
  addr_t     araddr;
  logic      arvalid;
  logic      arready;
  word_t     rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;
  addr_t     awaddr;
  logic      awvalid;
  logic      awready;
  word_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;

  logic [31:0] rng = 32'h7cf3_577b;
  word_t       model_mem [1 << word_bits];
  addr_t       ar_q [$];
  addr_t       aw_q [$];
  word_t       wd_q [$];
  strb_t       ws_q [$];
  logic        ar_fire, aw_fire, w_fire;
  logic        rvalid_seen, bvalid_seen;
  word_t       r_hold_data;
  axi_resp_t   r_hold_resp;
  axi_resp_t   b_hold_resp;
  logic        wr_active, aw_done, w_done;
  int          ar_total, aw_total, w_total, r_count, b_count;
  int          reads_started, writes_started;
  int          r_stall, b_stall;
  int          cycles;

  axil_sram_top #(
    .word_bits  (word_bits),
    .jitter_bits(4)
  ) DUT (
    .clk(clk), .rstn(rstn),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  always #50 clk = ~clk;

  // 32-bit Fibonacci LFSR, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      v = {v[30:0], rng[0]};
    end
    return v;
  endfunction

  function automatic logic in_range(input addr_t a);
    return (a >> idx_top) == '0;
  endfunction

  // one address in eight lands above the array, half the rest hit eight hot words
  function automatic addr_t pick_addr();
    logic [31:0] v;
    addr_t       a;
    v = rand_bits(3);
    if (v == 0) begin
      a = rand_bits(32);
      a[1:0] = 2'b00;
      if ((a >> idx_top) == '0) begin
        a[idx_top] = 1'b1;
      end
    end else begin
      a = '0;
      v = rand_bits(word_bits);
      if (rand_bits(1) != 0) begin
        v[word_bits-1:3] = '0;
      end
      a[idx_top-1:2] = v[word_bits-1:0];
    end
    return a;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (exp !== act) begin
      fail_now($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      fail_now($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_now($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      fail_now($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic take_write();
    addr_t                a;
    word_t                d;
    strb_t                s;
    logic [word_bits-1:0] idx;
    if (aw_q.size() == 0 || wd_q.size() == 0) begin
      fail_now("a write response appeared with no complete write outstanding");
    end else begin
      a = aw_q.pop_front();
      d = wd_q.pop_front();
      s = ws_q.pop_front();
      check_resp("write response", in_range(a) ? resp_okay : resp_slverr, bresp);
      if (in_range(a)) begin
        idx = a[idx_top-1:2];
        for (int b = 0; b < 4; b++) begin
          if (s[b]) begin
            model_mem[idx][8*b +: 8] = d[8*b +: 8];
          end
        end
      end
      b_hold_resp = bresp;
    end
  endtask

  task automatic take_read();
    addr_t                a;
    logic [word_bits-1:0] idx;
    if (ar_q.size() == 0) begin
      fail_now("a read response appeared with no read outstanding");
    end else begin
      a = ar_q.pop_front();
      check_resp("read response", in_range(a) ? resp_okay : resp_slverr, rresp);
      if (in_range(a)) begin
        idx = a[idx_top-1:2];
        check_data("read data", model_mem[idx], rdata);
      end
      r_hold_data = rdata;
      r_hold_resp = rresp;
    end
  endtask

  task automatic drive_read_addr();
    if (ar_fire) begin
      arvalid <= 1'b0;
    end
    if ((!arvalid || ar_fire) && reads_started < n_reads && rand_bits(1) != 0) begin
      arvalid <= 1'b1;
      araddr  <= pick_addr();
      reads_started++;
    end
  endtask

  // mode 1 raises AW first, mode 2 raises W first, the others raise both together
  task automatic drive_write_beats();
    logic [31:0] v;
    if (aw_fire) begin
      awvalid <= 1'b0;
      aw_done = 1'b1;
    end
    if (w_fire) begin
      wvalid <= 1'b0;
      w_done = 1'b1;
    end
    if (wr_active && aw_done && w_done) begin
      wr_active = 1'b0;
    end
    if (!wr_active) begin
      if (writes_started < n_writes && rand_bits(1) != 0) begin
        awaddr <= pick_addr();
        wdata  <= rand_bits(32);
        v = rand_bits(4);
        wstrb  <= v[3:0];
        v = rand_bits(2);
        awvalid <= (v[1:0] != 2'd2);
        wvalid  <= (v[1:0] != 2'd1);
        aw_done   = 1'b0;
        w_done    = 1'b0;
        wr_active = 1'b1;
        writes_started++;
      end
    end else begin
      if (aw_done && !w_done && !wvalid && rand_bits(1) != 0) begin
        wvalid <= 1'b1;
      end
      if (w_done && !aw_done && !awvalid && rand_bits(1) != 0) begin
        awvalid <= 1'b1;
      end
    end
  endtask

  // now and then a ready line stays low for up to 31 cycles
  task automatic drive_ready_levels();
    logic [31:0] v;
    if (r_stall > 0) begin
      rready <= 1'b0;
      r_stall--;
    end else begin
      v = rand_bits(4);
      if (v == 0) begin
        r_stall = rand_bits(5);
      end
      rready <= (v != 0) && (v[1:0] != 2'b00);
    end
    if (b_stall > 0) begin
      bready <= 1'b0;
      b_stall--;
    end else begin
      v = rand_bits(4);
      if (v == 0) begin
        b_stall = rand_bits(5);
      end
      bready <= (v != 0) && (v[1:0] != 2'b00);
    end
  endtask

  always @(posedge clk) begin
    if (!rstn) begin
      drive_read_addr();
      drive_write_beats();
      drive_ready_levels();
    end
  end

  // responses from the edge just past come first, then the beats of the coming edge
  always @(negedge clk) begin
    if (!rstn) begin
      if (bvalid && !bvalid_seen) begin
        take_write();
      end else if (bvalid) begin
        check_resp("bresp held under back-pressure", b_hold_resp, bresp);
      end
      if (rvalid && !rvalid_seen) begin
        take_read();
      end else if (rvalid) begin
        check_resp("rresp held under back-pressure", r_hold_resp, rresp);
        check_data("rdata held under back-pressure", r_hold_data, rdata);
      end
      rvalid_seen = rvalid;
      bvalid_seen = bvalid;
      ar_fire = arvalid & arready;
      aw_fire = awvalid & awready;
      w_fire  = wvalid & wready;
      if (ar_fire) begin
        ar_q.push_back(araddr);
        ar_total++;
      end
      if (aw_fire) begin
        aw_q.push_back(awaddr);
        aw_total++;
      end
      if (w_fire) begin
        wd_q.push_back(wdata);
        ws_q.push_back(wstrb);
        w_total++;
      end
      if (rvalid && rready) begin
        r_count++;
      end
      if (bvalid && bready) begin
        b_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the transactions did not complete within %0d cycles", timeout_cycles);
      $display("Errors found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  initial begin
    clk = 1'b0;
    rstn = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    wr_active = 1'b0;
    aw_done = 1'b0;
    w_done = 1'b0;
    for (int i = 0; i < (1 << word_bits); i++) begin
      model_mem[i] = '0;
    end
    // rstn is an active-high reset
    repeat (16) @(posedge clk);
    rstn <= 1'b0;
    @(negedge clk);
    check_flag("arready after reset", 1'b1, arready);
    check_flag("awready after reset", 1'b1, awready);
    check_flag("wready after reset", 1'b1, wready);
    check_flag("rvalid after reset", 1'b0, rvalid);
    check_flag("bvalid after reset", 1'b0, bvalid);
    while (r_count < n_reads || b_count < n_writes) begin
      @(posedge clk);
    end
    // idle long enough for any stray response to show up
    repeat (40) @(posedge clk);
    check_count("read requests", n_reads, ar_total);
    check_count("read responses", ar_total, r_count);
    check_count("write address beats", n_writes, aw_total);
    check_count("write data beats", n_writes, w_total);
    check_count("write responses", aw_total, b_count);
    check_count("reads left pending", 0, ar_q.size());
    check_count("writes left pending", 0, aw_q.size());
    $display("No errors");
    $finish;
  end

endmodule

//--- build.f
common/sram_pkg.sv
sram_model/lfsr8.sv
sram_model/axil_read_channel.sv
sram_model/axil_write_channel.sv
sram_model/sram_core.sv
rtl/axil_sram_top.sv
dv/tb_axil_sram.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log, then judge the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_axil_sram \
  -Mdir obj_dir -o tb_axil_sram -f build.f
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

./obj_dir/tb_axil_sram > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Errors found" "$log"; then
  echo "run_sim: FAIL"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "run_sim: simulator exited with status $run_status"
  exit 1
fi

echo "run_sim: PASS"
exit 0
